//--- source/dcache_consts.svh
// data cache geometry and queue depth constants
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// byte address and line offset
`define DC_ADDR_BITS 16
`define DC_OFFSET_BITS 3

// sets and ways, ways must be a power of two
`define DC_NUM_SETS 8
`define DC_SET_BITS 3
`define DC_NUM_WAYS 4

`define DC_TAG_BITS (`DC_ADDR_BITS - `DC_SET_BITS - `DC_OFFSET_BITS)

// one line is one 64-bit word
`define DC_DATA_BITS 64

`define DC_QUEUE_DEPTH 4

`endif

//--- source/dcache_pkg.sv
// data cache request, line, response, miss and victim types
`include "dcache_consts.svh"

package dcache_pkg;

	typedef struct packed {
		logic valid;
		logic [`DC_ADDR_BITS-1:0] addr;
	} rd_req_t;

	typedef struct packed {
		logic valid;
		logic [`DC_ADDR_BITS-1:0] addr;
		logic [`DC_DATA_BITS-1:0] data;
		logic dirty;
	} wr_req_t;

	typedef struct packed {
		logic [`DC_SET_BITS-1:0] idx;
		logic [`DC_TAG_BITS-1:0] tag;
	} line_addr_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		logic [`DC_TAG_BITS-1:0] tag;
		logic [`DC_DATA_BITS-1:0] data;
	} cache_line_t;

	typedef cache_line_t [`DC_NUM_WAYS-1:0] cache_set_t;

	typedef struct packed {
		logic valid;
		logic hit;
		logic [`DC_DATA_BITS-1:0] data;
	} rd_resp_t;

	typedef struct packed {
		line_addr_t line;
	} miss_t;

	typedef struct packed {
		line_addr_t line;
		logic [`DC_DATA_BITS-1:0] data;
	} victim_t;

endpackage

//--- source/req_decode.sv
// request decode, splits core addresses into index and tag and registers them
`timescale 1ns/1ps
`include "dcache_consts.svh"

module req_decode (
	input logic clock,
	input logic reset,
	input dcache_pkg::rd_req_t rd1_req,
	input dcache_pkg::rd_req_t rd2_req,
	input dcache_pkg::wr_req_t wr_req,
	output logic rd1_en,
	output logic rd2_en,
	output logic wr_en,
	output dcache_pkg::line_addr_t rd1_line,
	output dcache_pkg::line_addr_t rd2_line,
	output dcache_pkg::line_addr_t wr_line,
	output logic [`DC_DATA_BITS-1:0] wr_data,
	output logic wr_dirty
);

	// offset bits are dropped, a line is one word
	function automatic dcache_pkg::line_addr_t to_line(input logic [`DC_ADDR_BITS-1:0] addr);
		dcache_pkg::line_addr_t line;
		line.idx = addr[`DC_OFFSET_BITS +: `DC_SET_BITS];
		line.tag = addr[`DC_ADDR_BITS-1 -: `DC_TAG_BITS];
		return line;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			rd1_en <= 1'b0;
			rd2_en <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			rd1_en <= rd1_req.valid;
			rd2_en <= rd2_req.valid;
			wr_en <= wr_req.valid;
		end
	end

	always_ff @(posedge clock) begin
		rd1_line <= to_line(rd1_req.addr);
		rd2_line <= to_line(rd2_req.addr);
		wr_line <= to_line(wr_req.addr);
		wr_data <= wr_req.data;
		wr_dirty <= wr_req.dirty;
	end

endmodule

//--- source/plru_tree.sv
// tree pseudo-LRU touch update and victim selection for one set
`timescale 1ns/1ps
`include "dcache_consts.svh"

module plru_tree (
	input logic [`DC_NUM_WAYS-2:0] bits,
	input logic touch,
	input logic [$clog2(`DC_NUM_WAYS)-1:0] touch_way,
	output logic [`DC_NUM_WAYS-2:0] bits_next,
	output logic [$clog2(`DC_NUM_WAYS)-1:0] victim_way
);

	localparam int WAY_BITS = $clog2(`DC_NUM_WAYS);

	// node n has children 2n+1 (lower half) and 2n+2 (upper half)
	// a node bit of 0 marks the lower half as less recently used

	always_comb begin
		int node;
		node = 0;
		victim_way = '0;
		for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
			victim_way[WAY_BITS-1-lvl] = bits[node];
			node = 2 * node + 1 + int'(bits[node]);
		end
	end

	// point every node on the path away from the touched way
	always_comb begin
		int node;
		node = 0;
		bits_next = bits;
		if (touch) begin
			for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
				bits_next[node] = ~touch_way[WAY_BITS-1-lvl];
				node = 2 * node + 1 + int'(touch_way[WAY_BITS-1-lvl]);
			end
		end
	end

endmodule

//--- source/cachemem.sv
// set-associative line array with two read ports, one write port and pLRU replacement
`timescale 1ns/1ps
`include "dcache_consts.svh"

module cachemem (
	input logic clock,
	input logic reset,
	input logic rd1_en,
	input logic rd2_en,
	input logic wr_en,
	input dcache_pkg::line_addr_t rd1_line,
	input dcache_pkg::line_addr_t rd2_line,
	input dcache_pkg::line_addr_t wr_line,
	input logic [`DC_DATA_BITS-1:0] wr_data,
	input logic wr_dirty,
	output dcache_pkg::rd_resp_t rd1_resp,
	output dcache_pkg::rd_resp_t rd2_resp,
	output logic rd1_miss_valid,
	output dcache_pkg::miss_t rd1_miss,
	output logic rd2_miss_valid,
	output dcache_pkg::miss_t rd2_miss,
	output logic victim_push,
	output dcache_pkg::victim_t victim
);

	localparam int WAY_BITS = $clog2(`DC_NUM_WAYS);

	dcache_pkg::cache_set_t sets [`DC_NUM_SETS];
	logic [`DC_NUM_WAYS-2:0] plru [`DC_NUM_SETS];

	dcache_pkg::cache_set_t rd1_set, rd2_set, wr_set;
	dcache_pkg::cache_line_t new_line;
	logic [`DC_NUM_WAYS-1:0] rd1_match, rd2_match, wr_match, wr_invalid;
	logic [WAY_BITS-1:0] rd1_way, rd2_way, wr_way, plru_victim;
	logic [WAY_BITS-1:0] rd1_touch_way, rd2_touch_way;
	logic rd1_fwd, rd2_fwd, wr_hit;
	logic [`DC_NUM_WAYS-2:0] bits_wr, bits_rd1, bits_rd2;
	logic [`DC_NUM_WAYS-2:0] bits_rd1_in, bits_rd2_in;

	function automatic logic [`DC_NUM_WAYS-1:0] match_ways(input dcache_pkg::cache_set_t set,
			input logic [`DC_TAG_BITS-1:0] tag);
		logic [`DC_NUM_WAYS-1:0] m;
		for (int w = 0; w < `DC_NUM_WAYS; w++) begin
			m[w] = set[w].valid && (set[w].tag == tag);
		end
		return m;
	endfunction

	function automatic logic [WAY_BITS-1:0] lowest(input logic [`DC_NUM_WAYS-1:0] v);
		logic [WAY_BITS-1:0] way;
		way = '0;
		for (int w = `DC_NUM_WAYS - 1; w >= 0; w--) begin
			if (v[w]) way = WAY_BITS'(w);
		end
		return way;
	endfunction

	assign rd1_set = sets[rd1_line.idx];
	assign rd2_set = sets[rd2_line.idx];
	assign wr_set = sets[wr_line.idx];

	assign rd1_match = match_ways(rd1_set, rd1_line.tag);
	assign rd2_match = match_ways(rd2_set, rd2_line.tag);
	assign wr_match = match_ways(wr_set, wr_line.tag);
	assign rd1_way = lowest(rd1_match);
	assign rd2_way = lowest(rd2_match);

	// write way: hit way, else lowest invalid, else pLRU victim
	always_comb begin
		for (int w = 0; w < `DC_NUM_WAYS; w++) begin
			wr_invalid[w] = ~wr_set[w].valid;
		end
		wr_hit = |wr_match;
		if (wr_hit) wr_way = lowest(wr_match);
		else if (|wr_invalid) wr_way = lowest(wr_invalid);
		else wr_way = plru_victim;
	end

	assign new_line = '{valid: 1'b1, dirty: wr_dirty, tag: wr_line.tag, data: wr_data};

	// same-cycle write to the read line wins
	assign rd1_fwd = rd1_en & wr_en & (rd1_line == wr_line);
	assign rd2_fwd = rd2_en & wr_en & (rd2_line == wr_line);

	assign rd1_resp.valid = rd1_en;
	assign rd1_resp.hit = rd1_en & (rd1_fwd | (|rd1_match));
	assign rd1_resp.data = rd1_fwd ? wr_data : rd1_set[rd1_way].data;
	assign rd2_resp.valid = rd2_en;
	assign rd2_resp.hit = rd2_en & (rd2_fwd | (|rd2_match));
	assign rd2_resp.data = rd2_fwd ? wr_data : rd2_set[rd2_way].data;

	assign rd1_miss_valid = rd1_en & ~rd1_resp.hit;
	assign rd1_miss.line = rd1_line;
	assign rd2_miss_valid = rd2_en & ~rd2_resp.hit;
	assign rd2_miss.line = rd2_line;

	assign victim_push = wr_en & ~wr_hit & wr_set[wr_way].valid & wr_set[wr_way].dirty;
	assign victim.line = '{idx: wr_line.idx, tag: wr_set[wr_way].tag};
	assign victim.data = wr_set[wr_way].data;

	// touch chain: write, read 1, read 2; each stage sees earlier updates to its set
	assign rd1_touch_way = rd1_fwd ? wr_way : rd1_way;
	assign rd2_touch_way = rd2_fwd ? wr_way : rd2_way;
	assign bits_rd1_in = (rd1_line.idx == wr_line.idx) ? bits_wr : plru[rd1_line.idx];
	assign bits_rd2_in = (rd2_line.idx == rd1_line.idx) ? bits_rd1 :
		(rd2_line.idx == wr_line.idx) ? bits_wr : plru[rd2_line.idx];

	plru_tree u_plru_wr (
		.bits(plru[wr_line.idx]),
		.touch(wr_en),
		.touch_way(wr_way),
		.bits_next(bits_wr),
		.victim_way(plru_victim)
	);

	plru_tree u_plru_rd1 (
		.bits(bits_rd1_in),
		.touch(rd1_resp.hit),
		.touch_way(rd1_touch_way),
		.bits_next(bits_rd1),
		.victim_way()
	);

	// a repeat touch of the read 1 line leaves the bits as they are
	plru_tree u_plru_rd2 (
		.bits(bits_rd2_in),
		.touch(rd2_resp.hit),
		.touch_way(rd2_touch_way),
		.bits_next(bits_rd2),
		.victim_way()
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < `DC_NUM_SETS; s++) begin
				for (int w = 0; w < `DC_NUM_WAYS; w++) begin
					sets[s][w].valid <= 1'b0;
					sets[s][w].dirty <= 1'b0;
				end
				plru[s] <= '0;
			end
		end else begin
			if (wr_en) sets[wr_line.idx][wr_way] <= new_line;
			// later stages already hold earlier updates to a shared set
			plru[wr_line.idx] <= bits_wr;
			plru[rd1_line.idx] <= bits_rd1;
			plru[rd2_line.idx] <= bits_rd2;
		end
	end

endmodule

//--- source/miss_merge.sv
// merges the two read misses into fill-queue pushes
`timescale 1ns/1ps

module miss_merge (
	input logic rd1_miss_valid,
	input dcache_pkg::miss_t rd1_miss,
	input logic rd2_miss_valid,
	input dcache_pkg::miss_t rd2_miss,
	output logic [1:0] push_count,
	output dcache_pkg::miss_t push_lo,
	output dcache_pkg::miss_t push_hi
);

	logic same_line;

	assign same_line = (rd1_miss.line == rd2_miss.line);

	// high slot only matters with two pushes
	assign push_hi = rd2_miss;

	always_comb begin
		push_lo = rd1_miss;
		push_count = 2'd0;
		if (rd1_miss_valid && rd2_miss_valid) begin
			push_count = same_line ? 2'd1 : 2'd2;
		end else if (rd1_miss_valid) begin
			push_count = 2'd1;
		end else if (rd2_miss_valid) begin
			push_lo = rd2_miss;
			push_count = 2'd1;
		end
	end

endmodule

//--- source/sync_fifo.sv
// circular queue with one or two pushes per cycle and a sticky overflow flag
`timescale 1ns/1ps
`include "dcache_consts.svh"

module sync_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH = `DC_QUEUE_DEPTH
) (
	input logic clock,
	input logic reset,
	input logic [1:0] push_count,
	input payload_t push_lo,
	input payload_t push_hi,
	input logic pop,
	output payload_t head,
	output logic empty,
	output logic overflow
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_BITS-1:0] rd_ptr, wr_ptr, wr_ptr_hi;
	logic [CNT_BITS-1:0] count;
	logic do_pop, take_lo, take_hi, drop;
	int room;

	function automatic logic [PTR_BITS-1:0] bump(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// a pop frees its slot for pushes in the same cycle
	always_comb begin
		do_pop = pop & ~empty;
		room = DEPTH - int'(count) + int'(do_pop);
		take_lo = (push_count != 2'd0) && (room >= 1);
		take_hi = (push_count == 2'd2) && (room >= 2);
		drop = int'(push_count) > room;
	end

	assign wr_ptr_hi = bump(wr_ptr);
	assign head = mem[rd_ptr];
	assign empty = (count == '0);

	always_ff @(posedge clock) begin
		if (take_lo) mem[wr_ptr] <= push_lo;
		if (take_hi) mem[wr_ptr_hi] <= push_hi;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (take_hi) wr_ptr <= bump(wr_ptr_hi);
			else if (take_lo) wr_ptr <= wr_ptr_hi;
			if (do_pop) rd_ptr <= bump(rd_ptr);
			count <= count + CNT_BITS'(take_lo) + CNT_BITS'(take_hi) - CNT_BITS'(do_pop);
			// dropped entries keep the oldest ones in place
			if (drop) overflow <= 1'b1;
		end
	end

endmodule

//--- source/dcache_top.sv
// data cache array top, decode, line array, miss merge and fill/victim queues
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top (
	input logic clock,
	input logic reset,
	input dcache_pkg::rd_req_t rd1_req,
	input dcache_pkg::rd_req_t rd2_req,
	input dcache_pkg::wr_req_t wr_req,
	input logic miss_pop,
	input logic victim_pop,
	output dcache_pkg::rd_resp_t rd1_resp,
	output dcache_pkg::rd_resp_t rd2_resp,
	output dcache_pkg::miss_t miss_head,
	output logic miss_empty,
	output dcache_pkg::victim_t victim_head,
	output logic victim_empty,
	output logic overflow
);

	logic rd1_en, rd2_en, wr_en, wr_dirty;
	dcache_pkg::line_addr_t rd1_line, rd2_line, wr_line;
	logic [`DC_DATA_BITS-1:0] wr_data;
	logic rd1_miss_valid, rd2_miss_valid, victim_push;
	dcache_pkg::miss_t rd1_miss, rd2_miss, push_lo, push_hi;
	dcache_pkg::victim_t victim;
	logic [1:0] miss_push_count;
	logic miss_overflow, victim_overflow;

	req_decode u_req_decode (
		.clock(clock),
		.reset(reset),
		.rd1_req(rd1_req),
		.rd2_req(rd2_req),
		.wr_req(wr_req),
		.rd1_en(rd1_en),
		.rd2_en(rd2_en),
		.wr_en(wr_en),
		.rd1_line(rd1_line),
		.rd2_line(rd2_line),
		.wr_line(wr_line),
		.wr_data(wr_data),
		.wr_dirty(wr_dirty)
	);

	cachemem u_cachemem (
		.clock(clock),
		.reset(reset),
		.rd1_en(rd1_en),
		.rd2_en(rd2_en),
		.wr_en(wr_en),
		.rd1_line(rd1_line),
		.rd2_line(rd2_line),
		.wr_line(wr_line),
		.wr_data(wr_data),
		.wr_dirty(wr_dirty),
		.rd1_resp(rd1_resp),
		.rd2_resp(rd2_resp),
		.rd1_miss_valid(rd1_miss_valid),
		.rd1_miss(rd1_miss),
		.rd2_miss_valid(rd2_miss_valid),
		.rd2_miss(rd2_miss),
		.victim_push(victim_push),
		.victim(victim)
	);

	miss_merge u_miss_merge (
		.rd1_miss_valid(rd1_miss_valid),
		.rd1_miss(rd1_miss),
		.rd2_miss_valid(rd2_miss_valid),
		.rd2_miss(rd2_miss),
		.push_count(miss_push_count),
		.push_lo(push_lo),
		.push_hi(push_hi)
	);

	sync_fifo #(
		.payload_t(dcache_pkg::miss_t),
		.DEPTH(`DC_QUEUE_DEPTH)
	) u_miss_fifo (
		.clock(clock),
		.reset(reset),
		.push_count(miss_push_count),
		.push_lo(push_lo),
		.push_hi(push_hi),
		.pop(miss_pop),
		.head(miss_head),
		.empty(miss_empty),
		.overflow(miss_overflow)
	);

	// one victim at most per cycle
	sync_fifo #(
		.payload_t(dcache_pkg::victim_t),
		.DEPTH(`DC_QUEUE_DEPTH)
	) u_victim_fifo (
		.clock(clock),
		.reset(reset),
		.push_count({1'b0, victim_push}),
		.push_lo(victim),
		.push_hi(victim),
		.pop(victim_pop),
		.head(victim_head),
		.empty(victim_empty),
		.overflow(victim_overflow)
	);

	assign overflow = miss_overflow | victim_overflow;

endmodule

//--- tb/dcache_tb.sv
// data cache array testbench, directed tests checked against a reference model
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tb;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam int SETS = `DC_NUM_SETS;
	localparam int WAYS = `DC_NUM_WAYS;
	localparam int TAG_BITS = `DC_TAG_BITS;
	// about 60 cycles of requests and drains, with margin
	localparam int TEST_CYCLES = 80;
	localparam int WATCHDOG_NS = 4 * (TEST_CYCLES + 3 * RESET_CYCLES) * CLK_PERIOD;

	logic clock;
	logic reset;
	dcache_pkg::rd_req_t rd1_req, rd2_req;
	dcache_pkg::wr_req_t wr_req;
	logic miss_pop, victim_pop;
	dcache_pkg::rd_resp_t rd1_resp, rd2_resp;
	dcache_pkg::miss_t miss_head;
	dcache_pkg::victim_t victim_head;
	logic miss_empty, victim_empty, overflow;

	// reference model of the array, the tree bits and both queues
	logic m_valid [SETS][WAYS];
	logic m_dirty [SETS][WAYS];
	logic [TAG_BITS-1:0] m_tag [SETS][WAYS];
	logic [`DC_DATA_BITS-1:0] m_data [SETS][WAYS];
	logic [2:0] m_plru [SETS];
	dcache_pkg::miss_t miss_q [$];
	dcache_pkg::victim_t victim_q [$];
	logic m_overflow;
	logic [31:0] seed;

	dcache_top u_dcache_top (
		.clock(clock),
		.reset(reset),
		.rd1_req(rd1_req),
		.rd2_req(rd2_req),
		.wr_req(wr_req),
		.miss_pop(miss_pop),
		.victim_pop(victim_pop),
		.rd1_resp(rd1_resp),
		.rd2_resp(rd2_resp),
		.miss_head(miss_head),
		.miss_empty(miss_empty),
		.victim_head(victim_head),
		.victim_empty(victim_empty),
		.overflow(overflow)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Testbench failed");
		$fatal(1, "timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		// swap halves, low LCG bits repeat quickly
		return {seed[15:0], seed[31:16]};
	endfunction

	function automatic dcache_pkg::line_addr_t line_of(input logic [`DC_ADDR_BITS-1:0] addr);
		dcache_pkg::line_addr_t l;
		l.idx = addr[`DC_OFFSET_BITS +: `DC_SET_BITS];
		l.tag = addr[`DC_ADDR_BITS-1 -: TAG_BITS];
		return l;
	endfunction

	// random byte offset, it must not matter
	function automatic logic [`DC_ADDR_BITS-1:0] addr_of(input logic [`DC_SET_BITS-1:0] idx,
			input logic [TAG_BITS-1:0] tag);
		logic [31:0] r;
		r = lcg_next();
		return {tag, idx, r[`DC_OFFSET_BITS-1:0]};
	endfunction

	function automatic int find_way(input dcache_pkg::line_addr_t l);
		int way;
		way = -1;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (m_valid[l.idx][w] && m_tag[l.idx][w] == l.tag) way = w;
		end
		return way;
	endfunction

	function automatic int lowest_invalid(input logic [`DC_SET_BITS-1:0] idx);
		int way;
		way = -1;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!m_valid[idx][w]) way = w;
		end
		return way;
	endfunction

	// bit 0 is the root, bit 1 covers ways 0 and 1, bit 2 ways 2 and 3
	function automatic int tree_victim(input logic [2:0] b);
		if (!b[0]) return b[1] ? 1 : 0;
		return b[2] ? 3 : 2;
	endfunction

	function automatic logic [2:0] tree_touch(input logic [2:0] b, input int way);
		logic [2:0] n;
		n = b;
		n[0] = (way < 2);
		if (way < 2) n[1] = (way == 0);
		else n[2] = (way == 2);
		return n;
	endfunction

	function automatic logic [TAG_BITS-1:0] pick_absent(input logic [`DC_SET_BITS-1:0] idx,
			input logic [TAG_BITS-1:0] avoid);
		dcache_pkg::line_addr_t l;
		logic [31:0] r;
		l.idx = idx;
		do begin
			r = lcg_next();
			l.tag = r[TAG_BITS-1:0];
		end while (find_way(l) >= 0 || l.tag == avoid);
		return l.tag;
	endfunction

	task automatic model_reset();
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < WAYS; w++) begin
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
			end
			m_plru[s] = '0;
		end
		miss_q.delete();
		victim_q.delete();
		m_overflow = 1'b0;
	endtask

	task automatic push_miss(input dcache_pkg::line_addr_t l);
		dcache_pkg::miss_t m;
		m.line = l;
		if (miss_q.size() < `DC_QUEUE_DEPTH) miss_q.push_back(m);
		else m_overflow = 1'b1;
	endtask

	task automatic push_victim(input dcache_pkg::victim_t v);
		if (victim_q.size() < `DC_QUEUE_DEPTH) victim_q.push_back(v);
		else m_overflow = 1'b1;
	endtask

	task automatic check(input logic [127:0] got, input logic [127:0] expected,
			input string what);
		if (got !== expected) begin
			$display("Error at time %0t: %s, expected %0h, got %0h", $time, what, expected, got);
			$display("Testbench failed");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic check_resp(input dcache_pkg::rd_resp_t got, input logic v, input logic h,
			input logic [`DC_DATA_BITS-1:0] d, input string port);
		check(got.valid, v, {port, " valid"});
		if (v) check(got.hit, h, {port, " hit"});
		if (v && h) check(got.data, d, {port, " data"});
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		model_reset();
	endtask

	// one request cycle, called on a falling edge; checks the responses a cycle later
	task automatic issue(input logic r1v, input logic [`DC_ADDR_BITS-1:0] r1a,
			input logic r2v, input logic [`DC_ADDR_BITS-1:0] r2a,
			input logic wv, input logic [`DC_ADDR_BITS-1:0] wa,
			input logic [`DC_DATA_BITS-1:0] wd, input logic wdirty);
		dcache_pkg::line_addr_t l1, l2, lw;
		dcache_pkg::victim_t vic;
		logic f1, f2, h1, h2;
		logic [`DC_DATA_BITS-1:0] d1, d2;
		int w1, w2, ww;
		l1 = line_of(r1a);
		l2 = line_of(r2a);
		lw = line_of(wa);
		rd1_req = '{valid: r1v, addr: r1a};
		rd2_req = '{valid: r2v, addr: r2a};
		wr_req = '{valid: wv, addr: wa, data: wd, dirty: wdirty};
		// reads see the stored state unless the write names the same line
		f1 = r1v && wv && (l1 == lw);
		f2 = r2v && wv && (l2 == lw);
		w1 = find_way(l1);
		w2 = find_way(l2);
		h1 = r1v && (f1 || w1 >= 0);
		h2 = r2v && (f2 || w2 >= 0);
		d1 = f1 ? wd : (w1 >= 0 ? m_data[l1.idx][w1] : '0);
		d2 = f2 ? wd : (w2 >= 0 ? m_data[l2.idx][w2] : '0);
		ww = 0;
		if (wv) begin
			ww = find_way(lw);
			if (ww < 0) begin
				ww = lowest_invalid(lw.idx);
				if (ww < 0) ww = tree_victim(m_plru[lw.idx]);
				if (m_valid[lw.idx][ww] && m_dirty[lw.idx][ww]) begin
					vic.line = '{idx: lw.idx, tag: m_tag[lw.idx][ww]};
					vic.data = m_data[lw.idx][ww];
					push_victim(vic);
				end
			end
			m_valid[lw.idx][ww] = 1'b1;
			m_dirty[lw.idx][ww] = wdirty;
			m_tag[lw.idx][ww] = lw.tag;
			m_data[lw.idx][ww] = wd;
			m_plru[lw.idx] = tree_touch(m_plru[lw.idx], ww);
		end
		if (h1) m_plru[l1.idx] = tree_touch(m_plru[l1.idx], f1 ? ww : w1);
		// same line on both ports is a single touch
		if (h2 && !(h1 && l1 == l2)) m_plru[l2.idx] = tree_touch(m_plru[l2.idx], f2 ? ww : w2);
		if (r1v && !h1) push_miss(l1);
		if (r2v && !h2 && !(r1v && !h1 && l1 == l2)) push_miss(l2);
		@(negedge clock);
		check_resp(rd1_resp, r1v, h1, d1, "read 1");
		check_resp(rd2_resp, r2v, h2, d2, "read 2");
		rd1_req.valid = 1'b0;
		rd2_req.valid = 1'b0;
		wr_req.valid = 1'b0;
	endtask

	task automatic read_pair(input logic [`DC_ADDR_BITS-1:0] a1,
			input logic [`DC_ADDR_BITS-1:0] a2);
		issue(1'b1, a1, 1'b1, a2, 1'b0, '0, '0, 1'b0);
	endtask

	task automatic write_line(input logic [`DC_ADDR_BITS-1:0] a,
			input logic [`DC_DATA_BITS-1:0] d, input logic dirty);
		issue(1'b0, '0, 1'b0, '0, 1'b1, a, d, dirty);
	endtask

	// pops both queues to empty, comparing each head with the model
	task automatic drain_check();
		dcache_pkg::miss_t em;
		dcache_pkg::victim_t ev;
		@(negedge clock);
		check(overflow, m_overflow, "overflow");
		while (miss_q.size() > 0) begin
			em = miss_q.pop_front();
			check(miss_empty, 1'b0, "miss queue empty");
			check(miss_head, em, "miss queue head");
			miss_pop = 1'b1;
			@(negedge clock);
			miss_pop = 1'b0;
		end
		check(miss_empty, 1'b1, "miss queue empty after drain");
		while (victim_q.size() > 0) begin
			ev = victim_q.pop_front();
			check(victim_empty, 1'b0, "victim queue empty");
			check(victim_head, ev, "victim queue head");
			victim_pop = 1'b1;
			@(negedge clock);
			victim_pop = 1'b0;
		end
		check(victim_empty, 1'b1, "victim queue empty after drain");
	endtask

	task automatic test_fill_hit();
		logic [`DC_SET_BITS-1:0] idx;
		logic [TAG_BITS-1:0] base;
		logic [31:0] r;
		r = lcg_next();
		idx = r[`DC_SET_BITS-1:0];
		base = r[16 +: TAG_BITS];
		for (int k = 0; k < WAYS; k++) begin
			r = lcg_next();
			write_line(addr_of(idx, base + TAG_BITS'(k)), {lcg_next(), r}, r[0]);
		end
		for (int k = 0; k < WAYS; k++) begin
			read_pair(addr_of(idx, base + TAG_BITS'(k)), addr_of(idx, base + TAG_BITS'(k)));
		end
		drain_check();
	endtask

	task automatic test_read_miss();
		logic [`DC_SET_BITS-1:0] idx;
		logic [TAG_BITS-1:0] ta, tb;
		logic [31:0] r;
		r = lcg_next();
		idx = r[`DC_SET_BITS-1:0];
		ta = pick_absent(idx, '1);
		tb = pick_absent(idx, ta);
		read_pair(addr_of(idx, ta), addr_of(idx, tb));
		ta = pick_absent(idx, '1);
		read_pair(addr_of(idx, ta), addr_of(idx, ta));
		drain_check();
	endtask

	task automatic test_plru();
		logic [`DC_SET_BITS-1:0] idx;
		logic [TAG_BITS-1:0] tags [WAYS];
		logic [TAG_BITS-1:0] by_way [WAYS];
		logic [TAG_BITS-1:0] na, nb;
		dcache_pkg::line_addr_t l;
		logic [31:0] r;
		int d;
		r = lcg_next();
		idx = r[`DC_SET_BITS-1:0] + 3'd3;
		l.idx = idx;
		// only the first line is dirty
		for (int k = 0; k < WAYS; k++) begin
			tags[k] = pick_absent(idx, '1);
			write_line(addr_of(idx, tags[k]), {lcg_next(), lcg_next()}, k == 0);
		end
		for (int k = 0; k < WAYS; k++) begin
			l.tag = tags[k];
			by_way[find_way(l)] = tags[k];
		end
		l.tag = tags[0];
		d = find_way(l);
		// sibling first, then the other half, so the dirty line goes first and a clean one next
		read_pair(addr_of(idx, by_way[d ^ 1]), addr_of(idx, by_way[d ^ 2]));
		read_pair(addr_of(idx, by_way[d ^ 3]), addr_of(idx, by_way[d ^ 3]));
		na = pick_absent(idx, '1);
		write_line(addr_of(idx, na), {lcg_next(), lcg_next()}, 1'b1);
		nb = pick_absent(idx, '1);
		write_line(addr_of(idx, nb), {lcg_next(), lcg_next()}, 1'b0);
		read_pair(addr_of(idx, tags[0]), addr_of(idx, tags[1]));
		read_pair(addr_of(idx, tags[2]), addr_of(idx, tags[3]));
		read_pair(addr_of(idx, na), addr_of(idx, nb));
		drain_check();
	endtask

	task automatic test_forward();
		logic [`DC_SET_BITS-1:0] idx;
		logic [`DC_ADDR_BITS-1:0] a;
		logic [31:0] r;
		r = lcg_next();
		idx = r[`DC_SET_BITS-1:0];
		a = addr_of(idx, pick_absent(idx, '1));
		// write miss, then write hit, both read back in the same cycle
		issue(1'b1, a, 1'b1, a, 1'b1, a, {lcg_next(), lcg_next()}, 1'b1);
		issue(1'b1, a, 1'b0, '0, 1'b1, a, {lcg_next(), lcg_next()}, 1'b0);
		read_pair(a, a);
		drain_check();
	endtask

	task automatic test_overflow();
		logic [`DC_SET_BITS-1:0] idx;
		logic [TAG_BITS-1:0] ta, tb;
		logic [31:0] r;
		apply_reset();
		r = lcg_next();
		idx = r[`DC_SET_BITS-1:0];
		for (int i = 0; i < 3; i++) begin
			ta = pick_absent(idx, '1);
			tb = pick_absent(idx, ta);
			read_pair(addr_of(idx, ta), addr_of(idx, tb));
		end
		drain_check();
		check(overflow, 1'b1, "overflow after excess misses");
		apply_reset();
		check(overflow, 1'b0, "overflow after reset");
		check(miss_empty, 1'b1, "miss queue empty after reset");
		check(victim_empty, 1'b1, "victim queue empty after reset");
	endtask

	initial begin
		seed = 32'd91;
		reset = 1'b1;
		rd1_req = '0;
		rd2_req = '0;
		wr_req = '0;
		miss_pop = 1'b0;
		victim_pop = 1'b0;
		apply_reset();
		test_fill_hit();
		test_read_miss();
		test_plru();
		test_forward();
		test_overflow();
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+source
source/dcache_pkg.sv
source/req_decode.sv
source/plru_tree.sv
source/cachemem.sv
source/miss_merge.sv
source/sync_fifo.sv
source/dcache_top.sv
tb/dcache_tb.sv

//--- run.sh
#!/bin/sh
# build the data cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module dcache_tb \
	-f filelist.f -o dcache_sim \
	&& ./obj_dir/dcache_sim \
	|| exit 1
